// File: design/video_pkg.sv
/* video stream widths and the frame-buffer memory word
   shared by the packer, the top level and the testbench */
package video_pkg;

	localparam int CHAN_W = 8;
	localparam int SLOT_W = 4 * CHAN_W;	// pad, b, g, r
	localparam int WORD_W = 2 * SLOT_W;

	// one memory word as seen raw by the writer, or as two pixel slots
	typedef union packed {
		logic [WORD_W-1:0] raw;
		struct packed {
			logic [CHAN_W-1:0] hi_pad;	// older pixel
			logic [CHAN_W-1:0] hi_b;
			logic [CHAN_W-1:0] hi_g;
			logic [CHAN_W-1:0] hi_r;
			logic [CHAN_W-1:0] lo_pad;	// newer pixel
			logic [CHAN_W-1:0] lo_b;
			logic [CHAN_W-1:0] lo_g;
			logic [CHAN_W-1:0] lo_r;
		} pair;
	} mem_word_u;

endpackage

// File: design/ctrl_pkg.sv
/* output mode codes and camera power-up timing */
package ctrl_pkg;

	localparam int MODE_W = 4;

	localparam logic [MODE_W-1:0] MODE_CAM0 = 4'b0001;
	localparam logic [MODE_W-1:0] MODE_CAM1 = 4'b0010;
	localparam logic [MODE_W-1:0] MODE_HDR  = 4'b0011;	// merged exposure

	// camera reset held low this many cycles after reset release
	localparam int CAM_RESET_CYCLES = 2500;
	localparam int CAM_CNT_W = $clog2(CAM_RESET_CYCLES + 1);

endpackage

// File: design/cam_power_seq.sv
/* camera power-up sequencer: power-down follows system reset,
   camera reset released a fixed count after reset release */
`timescale 1ns/1ps

module cam_power_seq
(
	input  logic sys_clk_b,
	input  logic reset_n_b,
	output logic cam_pwdn_o,
	output logic cam_resetb_o
);
	import ctrl_pkg::*;

	logic [CAM_CNT_W-1:0] cnt_q;
	logic                 done;

	assign done = (cnt_q == CAM_CNT_W'(CAM_RESET_CYCLES));

	// runs once, parks at the terminal count
	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
			cnt_q <= '0;
		else if (!done)
			cnt_q <= cnt_q + 1'b1;
	end

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
			cam_resetb_o <= 1'b0;
		else if (done)
			cam_resetb_o <= 1'b1;	// sticky
	end

	assign cam_pwdn_o = !reset_n_b;

endmodule

// File: design/exposure_merge.sv
/* exposure merge stage: registers both camera pixels with
   their per-channel floor average */
`timescale 1ns/1ps

module exposure_merge
(
	input  logic                        sys_clk_b,
	input  logic                        reset_n_b,
	input  logic [video_pkg::CHAN_W-1:0] cam0_r_i,
	input  logic [video_pkg::CHAN_W-1:0] cam0_g_i,
	input  logic [video_pkg::CHAN_W-1:0] cam0_b_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_r_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_g_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_b_i,
	input  logic                        valid_i,
	input  logic                        sof_i,
	input  logic                        eof_i,
	input  logic                        ready_i,
	output logic                        ready_o,
	output logic [video_pkg::CHAN_W-1:0] cam0_r_o,
	output logic [video_pkg::CHAN_W-1:0] cam0_g_o,
	output logic [video_pkg::CHAN_W-1:0] cam0_b_o,
	output logic [video_pkg::CHAN_W-1:0] cam1_r_o,
	output logic [video_pkg::CHAN_W-1:0] cam1_g_o,
	output logic [video_pkg::CHAN_W-1:0] cam1_b_o,
	output logic [video_pkg::CHAN_W-1:0] hdr_r_o,
	output logic [video_pkg::CHAN_W-1:0] hdr_g_o,
	output logic [video_pkg::CHAN_W-1:0] hdr_b_o,
	output logic                        valid_o,
	output logic                        sof_o,
	output logic                        eof_o
);
	import video_pkg::*;

	// sum keeps the carry, bits 8:1 are the average
	function automatic logic [CHAN_W-1:0] avg2(input logic [CHAN_W-1:0] a,
		input logic [CHAN_W-1:0] b);
		logic [CHAN_W:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[CHAN_W:1];
	endfunction

	assign ready_o = !valid_o || ready_i;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
			valid_o <= 1'b0;
		else if (ready_o)
			valid_o <= valid_i;
	end

	always_ff @(posedge sys_clk_b)
	begin
		if (valid_i && ready_o)
		begin
			cam0_r_o <= cam0_r_i;
			cam0_g_o <= cam0_g_i;
			cam0_b_o <= cam0_b_i;
			cam1_r_o <= cam1_r_i;
			cam1_g_o <= cam1_g_i;
			cam1_b_o <= cam1_b_i;
			hdr_r_o  <= avg2(cam0_r_i, cam1_r_i);
			hdr_g_o  <= avg2(cam0_g_i, cam1_g_i);
			hdr_b_o  <= avg2(cam0_b_i, cam1_b_i);
			sof_o    <= sof_i;
			eof_o    <= eof_i;
		end
	end

endmodule

// File: design/stream_mode_select.sv
/* output source selector, mode latched once per frame at start of frame */
`timescale 1ns/1ps

module stream_mode_select
(
	input  logic                        sys_clk_b,
	input  logic                        reset_n_b,
	input  logic [ctrl_pkg::MODE_W-1:0]  mode_i,
	input  logic [video_pkg::CHAN_W-1:0] cam0_r_i,
	input  logic [video_pkg::CHAN_W-1:0] cam0_g_i,
	input  logic [video_pkg::CHAN_W-1:0] cam0_b_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_r_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_g_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_b_i,
	input  logic [video_pkg::CHAN_W-1:0] hdr_r_i,
	input  logic [video_pkg::CHAN_W-1:0] hdr_g_i,
	input  logic [video_pkg::CHAN_W-1:0] hdr_b_i,
	input  logic                        valid_i,
	input  logic                        sof_i,
	input  logic                        eof_i,
	input  logic                        ready_i,
	output logic                        ready_o,
	output logic [video_pkg::CHAN_W-1:0] r_o,
	output logic [video_pkg::CHAN_W-1:0] g_o,
	output logic [video_pkg::CHAN_W-1:0] b_o,
	output logic                        valid_o,
	output logic                        sof_o,
	output logic                        eof_o
);
	import ctrl_pkg::*;

	logic              accept;
	logic [MODE_W-1:0] mode_q;
	logic [MODE_W-1:0] sel_mode;

	assign ready_o  = !valid_o || ready_i;
	assign accept   = valid_i && ready_o;
	assign sel_mode = sof_i ? mode_i : mode_q;	// sof pixel already uses new mode

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			mode_q  <= MODE_CAM0;
			valid_o <= 1'b0;
		end
		else
		begin
			if (accept && sof_i)
				mode_q <= mode_i;
			if (ready_o)
				valid_o <= valid_i;
		end
	end

	always_ff @(posedge sys_clk_b)
	begin
		if (accept)
		begin
			case (sel_mode)
				MODE_CAM1: {r_o, g_o, b_o} <= {cam1_r_i, cam1_g_i, cam1_b_i};
				MODE_HDR:  {r_o, g_o, b_o} <= {hdr_r_i, hdr_g_i, hdr_b_i};
				default:   {r_o, g_o, b_o} <= {cam0_r_i, cam0_g_i, cam0_b_i};
			endcase
			sof_o <= sof_i;
			eof_o <= eof_i;
		end
	end

endmodule

// File: design/pixel_packer.sv
/* pairs pixels into 64-bit frame-buffer words, older pixel upper,
   an odd pixel at end of frame goes out with a zero lower slot */
`timescale 1ns/1ps

module pixel_packer
(
	input  logic                        sys_clk_b,
	input  logic                        reset_n_b,
	input  logic [video_pkg::CHAN_W-1:0] r_i,
	input  logic [video_pkg::CHAN_W-1:0] g_i,
	input  logic [video_pkg::CHAN_W-1:0] b_i,
	input  logic                        valid_i,
	input  logic                        sof_i,
	input  logic                        eof_i,
	input  logic                        ready_i,
	output logic                        ready_o,
	output video_pkg::mem_word_u        word_o,
	output logic                        valid_o,
	output logic                        sof_o,
	output logic                        eof_o
);
	import video_pkg::*;

	logic              accept;
	logic              word_done;
	logic              half_q;	// first pixel of a pair held
	logic [CHAN_W-1:0] hold_r;
	logic [CHAN_W-1:0] hold_g;
	logic [CHAN_W-1:0] hold_b;
	logic              hold_sof;

	assign ready_o   = !valid_o || ready_i;
	assign accept    = valid_i && ready_o;
	assign word_done = accept && (half_q || eof_i);

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			half_q  <= 1'b0;
			valid_o <= 1'b0;
		end
		else
		begin
			valid_o <= word_done || (valid_o && !ready_i);
			if (accept)
				half_q <= !half_q && !eof_i;
		end
	end

	always_ff @(posedge sys_clk_b)
	begin
		if (accept && !half_q)
		begin
			hold_r   <= r_i;
			hold_g   <= g_i;
			hold_b   <= b_i;
			hold_sof <= sof_i;
		end
		if (word_done)
		begin
			word_o.pair.hi_pad <= '0;
			word_o.pair.lo_pad <= '0;
			eof_o              <= eof_i;
			if (half_q)
			begin
				word_o.pair.hi_b <= hold_b;
				word_o.pair.hi_g <= hold_g;
				word_o.pair.hi_r <= hold_r;
				word_o.pair.lo_b <= b_i;
				word_o.pair.lo_g <= g_i;
				word_o.pair.lo_r <= r_i;
				sof_o            <= hold_sof;
			end
			else
			begin	// lone pixel closing the frame
				word_o.pair.hi_b <= b_i;
				word_o.pair.hi_g <= g_i;
				word_o.pair.hi_r <= r_i;
				word_o.pair.lo_b <= '0;
				word_o.pair.lo_g <= '0;
				word_o.pair.lo_r <= '0;
				sof_o            <= sof_i;
			end
		end
	end

endmodule

// File: design/hdr_video_top.sv
/* dual-camera HDR stream path: merge, mode select and word packing,
   with the camera power-up sequencer alongside */
`timescale 1ns/1ps

module hdr_video_top
(
	input  logic                        sys_clk_b,
	input  logic                        reset_n_b,
	input  logic [ctrl_pkg::MODE_W-1:0]  mode_i,
	input  logic [video_pkg::CHAN_W-1:0] cam0_r_i,
	input  logic [video_pkg::CHAN_W-1:0] cam0_g_i,
	input  logic [video_pkg::CHAN_W-1:0] cam0_b_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_r_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_g_i,
	input  logic [video_pkg::CHAN_W-1:0] cam1_b_i,
	input  logic                        in_valid_i,
	input  logic                        in_sof_i,
	input  logic                        in_eof_i,
	input  logic                        word_ready_i,
	output logic                        in_ready_o,
	output video_pkg::mem_word_u        word_o,
	output logic                        word_valid_o,
	output logic                        word_sof_o,
	output logic                        word_eof_o,
	output logic                        cam_pwdn_o,
	output logic                        cam_resetb_o
);
	import video_pkg::*;

	// merge -> select
	logic [CHAN_W-1:0] m_cam0_r, m_cam0_g, m_cam0_b;
	logic [CHAN_W-1:0] m_cam1_r, m_cam1_g, m_cam1_b;
	logic [CHAN_W-1:0] m_hdr_r, m_hdr_g, m_hdr_b;
	logic              m_valid, m_sof, m_eof, m_ready;

	// select -> packer
	logic [CHAN_W-1:0] s_r, s_g, s_b;
	logic              s_valid, s_sof, s_eof, s_ready;

	cam_power_seq u_cam_power_seq
	(
		.sys_clk_b    (sys_clk_b),
		.reset_n_b    (reset_n_b),
		.cam_pwdn_o   (cam_pwdn_o),
		.cam_resetb_o (cam_resetb_o)
	);

	exposure_merge u_exposure_merge
	(
		.sys_clk_b (sys_clk_b),    .reset_n_b (reset_n_b),
		.cam0_r_i  (cam0_r_i),     .cam0_g_i  (cam0_g_i),   .cam0_b_i (cam0_b_i),
		.cam1_r_i  (cam1_r_i),     .cam1_g_i  (cam1_g_i),   .cam1_b_i (cam1_b_i),
		.valid_i   (in_valid_i),   .sof_i     (in_sof_i),   .eof_i    (in_eof_i),
		.ready_i   (m_ready),      .ready_o   (in_ready_o),
		.cam0_r_o  (m_cam0_r),     .cam0_g_o  (m_cam0_g),   .cam0_b_o (m_cam0_b),
		.cam1_r_o  (m_cam1_r),     .cam1_g_o  (m_cam1_g),   .cam1_b_o (m_cam1_b),
		.hdr_r_o   (m_hdr_r),      .hdr_g_o   (m_hdr_g),    .hdr_b_o  (m_hdr_b),
		.valid_o   (m_valid),      .sof_o     (m_sof),      .eof_o    (m_eof)
	);

	stream_mode_select u_stream_mode_select
	(
		.sys_clk_b (sys_clk_b),    .reset_n_b (reset_n_b),  .mode_i   (mode_i),
		.cam0_r_i  (m_cam0_r),     .cam0_g_i  (m_cam0_g),   .cam0_b_i (m_cam0_b),
		.cam1_r_i  (m_cam1_r),     .cam1_g_i  (m_cam1_g),   .cam1_b_i (m_cam1_b),
		.hdr_r_i   (m_hdr_r),      .hdr_g_i   (m_hdr_g),    .hdr_b_i  (m_hdr_b),
		.valid_i   (m_valid),      .sof_i     (m_sof),      .eof_i    (m_eof),
		.ready_i   (s_ready),      .ready_o   (m_ready),
		.r_o       (s_r),          .g_o       (s_g),        .b_o      (s_b),
		.valid_o   (s_valid),      .sof_o     (s_sof),      .eof_o    (s_eof)
	);

	pixel_packer u_pixel_packer
	(
		.sys_clk_b (sys_clk_b),    .reset_n_b (reset_n_b),
		.r_i       (s_r),          .g_i       (s_g),        .b_i      (s_b),
		.valid_i   (s_valid),      .sof_i     (s_sof),      .eof_i    (s_eof),
		.ready_i   (word_ready_i), .ready_o   (s_ready),
		.word_o    (word_o),       .valid_o   (word_valid_o),
		.sof_o     (word_sof_o),   .eof_o     (word_eof_o)
	);

endmodule

// File: verif/tb_tasks.svh
/* testbench helpers: value check, LFSR bits, pixel driver and word collector */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic stop_with_failure(input string why);
	$display("%s", why);
	$display("Finished with errors");
	$fatal(1, "run stopped at first error");
endtask

task automatic compare_value(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp)
		stop_with_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
endtask

// galois form, taps 32 22 2 1
function automatic logic lfsr_bit();
	logic out;
	out = lfsr_state[0];
	lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h80200003 : 32'h0);
	return out;
endfunction

// holds each pixel until the merge stage takes it
task automatic drive_pixels(input int n, input logic [3:0] mode, input int mid_at,
	input logic [3:0] mid_mode);
	int i;
	i = 0;
	while (i < n)
	begin
		@(negedge sys_clk_b);
		mode_i     = (i > mid_at) ? mid_mode : mode;
		{cam0_r_i, cam0_g_i, cam0_b_i} = cam0_px[i];
		{cam1_r_i, cam1_g_i, cam1_b_i} = cam1_px[i];
		in_sof_i   = (i == 0);
		in_eof_i   = (i == n - 1);
		in_valid_i = 1'b1;
		#1;
		if (in_ready_o)
			i++;
	end
	@(negedge sys_clk_b);
	in_valid_i = 1'b0;
	in_sof_i   = 1'b0;
	in_eof_i   = 1'b0;
endtask

task automatic collect_words(input int n, input bit bp);
	int k;
	int words;
	mem_word_u w;
	logic [31:0] lo_exp;
	k = 0;
	words = (n + 1) / 2;
	while (k < words)
	begin
		@(negedge sys_clk_b);
		word_ready_i = bp ? lfsr_bit() : 1'b1;
		#1;
		if (word_valid_o && word_ready_i)
		begin
			w = word_o;
			lo_exp = (2 * k + 1 < n) ? slot_of(exp_px[2 * k + 1]) : 32'h0;	// odd tail
			compare_value("word_o upper slot",
				{w.pair.hi_pad, w.pair.hi_b, w.pair.hi_g, w.pair.hi_r}, slot_of(exp_px[2 * k]));
			compare_value("word_o lower slot",
				{w.pair.lo_pad, w.pair.lo_b, w.pair.lo_g, w.pair.lo_r}, lo_exp);
			compare_value("word_sof_o", 32'(word_sof_o), 32'(k == 0));
			compare_value("word_eof_o", 32'(word_eof_o), 32'(k == words - 1));
			k++;
		end
	end
endtask

`endif

// File: verif/tb_hdr_video_top.sv
/* testbench for the dual-camera HDR stream path covering the power sequence,
   source modes, frame-aligned mode latch and back-pressure */
`timescale 1ns/1ps

module tb_hdr_video_top;
	import video_pkg::*;
	import ctrl_pkg::*;

	localparam int CLK_HALF     = 50;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_FRAMES   = 8;
	localparam int FRAME_CYCLES = 64;	// generous enough for stalls
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + CAM_RESET_CYCLES
		+ NUM_FRAMES * FRAME_CYCLES;

	logic              sys_clk_b;
	logic              reset_n_b;
	logic [MODE_W-1:0] mode_i;
	logic [CHAN_W-1:0] cam0_r_i, cam0_g_i, cam0_b_i;
	logic [CHAN_W-1:0] cam1_r_i, cam1_g_i, cam1_b_i;
	logic              in_valid_i, in_sof_i, in_eof_i, in_ready_o;
	logic              word_ready_i, word_valid_o, word_sof_o, word_eof_o;
	mem_word_u         word_o;
	logic              cam_pwdn_o, cam_resetb_o;

	logic [31:0] lfsr_state = 32'h4890f147;
	logic [23:0] cam0_px[$];	// {r, g, b}
	logic [23:0] cam1_px[$];
	logic [23:0] exp_px[$];
	int          cycle_cnt = 0;

	`include "tb_tasks.svh"

	hdr_video_top UUT
	(
		.sys_clk_b (sys_clk_b), .reset_n_b (reset_n_b), .mode_i (mode_i),
		.cam0_r_i (cam0_r_i), .cam0_g_i (cam0_g_i), .cam0_b_i (cam0_b_i),
		.cam1_r_i (cam1_r_i), .cam1_g_i (cam1_g_i), .cam1_b_i (cam1_b_i),
		.in_valid_i (in_valid_i), .in_sof_i (in_sof_i), .in_eof_i (in_eof_i),
		.word_ready_i (word_ready_i), .in_ready_o (in_ready_o), .word_o (word_o),
		.word_valid_o (word_valid_o), .word_sof_o (word_sof_o),
		.word_eof_o (word_eof_o), .cam_pwdn_o (cam_pwdn_o), .cam_resetb_o (cam_resetb_o)
	);

	always #CLK_HALF sys_clk_b = ~sys_clk_b;

	always @(posedge sys_clk_b)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES)
			stop_with_failure("timeout: the tests did not complete in the allowed cycles");
	end

	function automatic logic [31:0] slot_of(input logic [23:0] px);
		return {8'h00, px[7:0], px[15:8], px[23:16]};	// pad, b, g, r
	endfunction

	// source picked by the mode latched at sof
	function automatic logic [23:0] pick_source(input logic [3:0] mode,
		input logic [23:0] a, input logic [23:0] b);
		logic [8:0]  s;
		logic [23:0] avg;
		for (int c = 0; c < 3; c++)
		begin
			s = ({1'b0, a[c * 8 +: 8]} + {1'b0, b[c * 8 +: 8]}) / 9'd2;
			avg[c * 8 +: 8] = s[7:0];
		end
		case (mode)
			MODE_CAM1: return b;
			MODE_HDR:  return avg;
			default:   return a;	// unknown codes give camera 0
		endcase
	endfunction

	task automatic fill_random(input int n);
		logic [23:0] p;
		cam0_px.delete();
		cam1_px.delete();
		for (int i = 0; i < 2 * n; i++)
		begin
			for (int j = 0; j < 24; j++)
				p = {p[22:0], lfsr_bit()};
			if (i < n)
				cam0_px.push_back(p);
			else
				cam1_px.push_back(p);
		end
	endtask

	task automatic run_frame(input int n, input logic [3:0] mode, input int mid_at,
		input logic [3:0] mid_mode, input bit bp);
		exp_px.delete();
		for (int i = 0; i < n; i++)
			exp_px.push_back(pick_source(mode, cam0_px[i], cam1_px[i]));
		fork
			drive_pixels(n, mode, mid_at, mid_mode);
			collect_words(n, bp);
		join
		@(negedge sys_clk_b);
		#1;
		compare_value("word_valid_o", 32'(word_valid_o), 32'h0);	// no extra word
	endtask

	// memory side held off until the chain is full, then the frame drains
	task automatic stall_then_drain(input int n, input int stall);
		repeat (stall)
		begin
			@(negedge sys_clk_b);
			word_ready_i = 1'b0;
		end
		#1;
		compare_value("in_ready_o", 32'(in_ready_o), 32'h0);
		collect_words(n, 1'b0);
	endtask

	task automatic test_power_seq();
		repeat (RESET_CYCLES)
		begin
			@(negedge sys_clk_b);
			compare_value("cam_pwdn_o", 32'(cam_pwdn_o), 32'h1);
			compare_value("cam_resetb_o", 32'(cam_resetb_o), 32'h0);
		end
		reset_n_b = 1'b1;
		#1;
		compare_value("cam_pwdn_o", 32'(cam_pwdn_o), 32'h0);
		compare_value("cam_resetb_o", 32'(cam_resetb_o), 32'h0);
		repeat (CAM_RESET_CYCLES)
			@(negedge sys_clk_b);
		compare_value("cam_resetb_o", 32'(cam_resetb_o), 32'h0);
		@(negedge sys_clk_b);
		compare_value("cam_resetb_o", 32'(cam_resetb_o), 32'h1);
	endtask

	task automatic test_pass_through();
		fill_random(8);
		run_frame(8, MODE_CAM0, 8, MODE_CAM0, 1'b0);
		fill_random(8);
		run_frame(8, MODE_CAM1, 8, MODE_CAM1, 1'b0);
	endtask

	task automatic test_hdr_average();
		fill_random(8);
		cam0_px[2] = 24'hfffeff;	// odd sums round down
		cam1_px[2] = 24'hfefffe;
		cam0_px[3] = 24'h000100;
		cam1_px[3] = 24'h010001;
		run_frame(8, MODE_HDR, 8, MODE_HDR, 1'b0);
		fill_random(6);
		run_frame(6, 4'b0111, 6, 4'b0111, 1'b0);
	endtask

	task automatic test_mode_latch();
		fill_random(8);
		run_frame(8, MODE_CAM1, 3, MODE_HDR, 1'b0);
		fill_random(8);
		run_frame(8, MODE_HDR, 8, MODE_HDR, 1'b0);
	endtask

	task automatic test_back_pressure();
		fill_random(5);
		run_frame(5, MODE_HDR, 5, MODE_HDR, 1'b1);
		// four pixels fill the chain, the fifth waits on in_ready_o
		fill_random(6);
		exp_px.delete();
		for (int i = 0; i < 6; i++)
			exp_px.push_back(pick_source(MODE_CAM1, cam0_px[i], cam1_px[i]));
		fork
			drive_pixels(6, MODE_CAM1, 6, MODE_CAM1);
			stall_then_drain(6, 6);
		join
		@(negedge sys_clk_b);
		#1;
		compare_value("word_valid_o", 32'(word_valid_o), 32'h0);
	endtask

	initial
	begin
		sys_clk_b    = 1'b0;
		reset_n_b    = 1'b0;
		mode_i       = MODE_CAM0;
		{cam0_r_i, cam0_g_i, cam0_b_i} = '0;
		{cam1_r_i, cam1_g_i, cam1_b_i} = '0;
		in_valid_i   = 1'b0;
		in_sof_i     = 1'b0;
		in_eof_i     = 1'b0;
		word_ready_i = 1'b1;
		test_power_seq();
		test_pass_through();
		test_hdr_average();
		test_mode_latch();
		test_back_pressure();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: files.f
design/video_pkg.sv
design/ctrl_pkg.sv
design/cam_power_seq.sv
design/exposure_merge.sv
design/stream_mode_select.sv
design/pixel_packer.sv
design/hdr_video_top.sv
+incdir+verif
verif/tb_hdr_video_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_hdr_video_top
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
